// ==== ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data path width
`define XLEN 64

// word variants operate on the low half
`define WORD_W 32

`define REG_IDX_W 5

// immediate as delivered by decode, sign-extended in execute
`define IMM_W 20

// shift amounts, 64-bit and word forms
`define SHAMT_W 6
`define SHAMTW_W 5

// lui and auipc place the immediate above bit 12
`define LUI_SHIFT 12
`define LINK_OFFSET 4

`endif

// ==== rv_isa_pkg.sv ====
`default_nettype none

`include "ex_params.svh"

package rv_isa_pkg;

    // kept RV64I mnemonics; nop doubles as the bubble opcode
    typedef enum logic [5:0] {
        op_nop,
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_addi, op_andi, op_ori, op_xori,
        op_slli, op_srli, op_srai, op_slti, op_sltiu,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_lui, op_auipc,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr
    } opcode_e;

    // memory access width
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_double
    } access_size_e;

    // decode hands over a short immediate
    function automatic logic [`XLEN-1:0] sext_imm(input logic [`IMM_W-1:0] imm);
        return {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
    endfunction

    // word results are sign-extended from bit 31
    function automatic logic [`XLEN-1:0] sext_word(input logic [`WORD_W-1:0] w);
        return {{(`XLEN-`WORD_W){w[`WORD_W-1]}}, w};
    endfunction

endpackage

`default_nettype wire

// ==== ex_pipe_pkg.sv ====
`default_nettype none

`include "ex_params.svh"

package ex_pipe_pkg;

    // one decoded instruction from decode
    typedef struct packed {
        logic                    valid;
        rv_isa_pkg::opcode_e     op;
        logic [`REG_IDX_W-1:0]   rd;
        logic [`REG_IDX_W-1:0]   rs1_idx;
        logic [`REG_IDX_W-1:0]   rs2_idx;
        logic [`XLEN-1:0]        rs1_val;
        logic [`XLEN-1:0]        rs2_val;
        logic [`IMM_W-1:0]       imm;
        logic [`XLEN-1:0]        pc;
    } id_ex_t;

    // result fed back from a later stage
    typedef struct packed {
        logic                    wb_en;
        logic [`REG_IDX_W-1:0]   rd;
        logic [`XLEN-1:0]        value;
    } fwd_t;

    // execute output towards the memory stage
    typedef struct packed {
        logic                       valid;
        logic                       wb_en;
        logic [`REG_IDX_W-1:0]      rd;
        logic [`XLEN-1:0]           result;
        logic [`XLEN-1:0]           store_data;
        logic                       mem_en;
        logic                       load;
        rv_isa_pkg::access_size_e   size;
        logic                       is_unsigned;
    } ex_mem_t;

    // fetch redirect for taken branches and jumps
    typedef struct packed {
        logic                    taken;
        logic [`XLEN-1:0]        target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module operand_bypass (
    input  ex_pipe_pkg::id_ex_t   id_ex,
    input  ex_pipe_pkg::ex_mem_t  ex_fwd,
    input  ex_pipe_pkg::fwd_t     mem_fwd,
    input  ex_pipe_pkg::fwd_t     wb_fwd,
    output logic [`XLEN-1:0]      rs1_op,
    output logic [`XLEN-1:0]      rs2_op,
    output logic                  load_use
);

    import ex_pipe_pkg::*;

    fwd_t ex_src;
    logic rs1_dep;
    logic rs2_dep;

    function automatic logic fwd_hit(input fwd_t src, input logic [`REG_IDX_W-1:0] idx);
        return src.wb_en && (src.rd == idx);
    endfunction

    // execute, then memory, then writeback, then the register file value
    function automatic logic [`XLEN-1:0] select_operand(
        input logic [`REG_IDX_W-1:0] idx,
        input logic [`XLEN-1:0]      dec_val,
        input fwd_t                  ex_in,
        input fwd_t                  mem_in,
        input fwd_t                  wb_in
    );
        if (idx == '0) begin
            return dec_val;
        end
        if (fwd_hit(ex_in, idx)) begin
            return ex_in.value;
        end
        if (fwd_hit(mem_in, idx)) begin
            return mem_in.value;
        end
        if (fwd_hit(wb_in, idx)) begin
            return wb_in.value;
        end
        return dec_val;
    endfunction

    // a load has no data yet while still in execute
    always_comb begin
        ex_src.wb_en = ex_fwd.wb_en && !ex_fwd.load;
        ex_src.rd    = ex_fwd.rd;
        ex_src.value = ex_fwd.result;
    end

    always_comb begin
        rs1_op = select_operand(id_ex.rs1_idx, id_ex.rs1_val, ex_src, mem_fwd, wb_fwd);
        rs2_op = select_operand(id_ex.rs2_idx, id_ex.rs2_val, ex_src, mem_fwd, wb_fwd);
    end

    // x0 never depends on anything
    assign rs1_dep = (id_ex.rs1_idx != '0) && (id_ex.rs1_idx == ex_fwd.rd);
    assign rs2_dep = (id_ex.rs2_idx != '0) && (id_ex.rs2_idx == ex_fwd.rd);

    assign load_use = id_ex.valid && ex_fwd.valid && ex_fwd.load && (rs1_dep || rs2_dep);

endmodule

`default_nettype wire

// ==== int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module int_alu (
    input  rv_isa_pkg::opcode_e   op,
    input  logic [`XLEN-1:0]      rs1_op,
    input  logic [`XLEN-1:0]      rs2_op,
    input  logic [`IMM_W-1:0]     imm,
    input  logic [`XLEN-1:0]      pc,
    output logic [`XLEN-1:0]      result
);

    import rv_isa_pkg::*;

    logic                   use_imm;
    logic [`XLEN-1:0]       imm_sx;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       sum;
    logic [`XLEN-1:0]       diff;
    logic [`XLEN-1:0]       upper_imm;
    logic [`SHAMT_W-1:0]    shamt;
    logic [`SHAMTW_W-1:0]   shamt_w;

    // immediate forms, plus loads and stores for the address add
    always_comb begin
        case (op)
            op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu,
            op_slli, op_srli, op_srai, op_addiw, op_slliw, op_srliw, op_sraiw,
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
            op_sb, op_sh, op_sw, op_sd: use_imm = 1'b1;
            default: use_imm = 1'b0;
        endcase
    end

    assign imm_sx    = sext_imm(imm);
    assign op_b      = use_imm ? imm_sx : rs2_op;
    assign sum       = rs1_op + op_b;
    assign diff      = rs1_op - op_b;
    assign upper_imm = imm_sx << `LUI_SHIFT;

    // srai takes all six bits, the word forms only five
    assign shamt   = op_b[`SHAMT_W-1:0];
    assign shamt_w = op_b[`SHAMTW_W-1:0];

    always_comb begin
        case (op)
            op_add, op_addi,
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
            op_sb, op_sh, op_sw, op_sd: result = sum;
            op_sub:            result = diff;
            op_and, op_andi:   result = rs1_op & op_b;
            op_or, op_ori:     result = rs1_op | op_b;
            op_xor, op_xori:   result = rs1_op ^ op_b;
            op_sll, op_slli:   result = rs1_op << shamt;
            op_srl, op_srli:   result = rs1_op >> shamt;
            op_sra, op_srai:   result = $signed(rs1_op) >>> shamt;
            op_slt, op_slti: begin
                result = {{(`XLEN-1){1'b0}}, ($signed(rs1_op) < $signed(op_b))};
            end
            op_sltu, op_sltiu: begin
                result = {{(`XLEN-1){1'b0}}, (rs1_op < op_b)};
            end
            // word forms work on the low half only
            op_addw, op_addiw: result = sext_word(sum[`WORD_W-1:0]);
            op_subw:           result = sext_word(diff[`WORD_W-1:0]);
            op_sllw, op_slliw: result = sext_word(rs1_op[`WORD_W-1:0] << shamt_w);
            op_srlw, op_srliw: result = sext_word(rs1_op[`WORD_W-1:0] >> shamt_w);
            op_sraw, op_sraiw: begin
                result = sext_word($signed(rs1_op[`WORD_W-1:0]) >>> shamt_w);
            end
            op_lui:            result = upper_imm;
            op_auipc:          result = pc + upper_imm;
            // link value
            op_jal, op_jalr:   result = pc + `XLEN'(`LINK_OFFSET);
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module branch_unit (
    input  rv_isa_pkg::opcode_e      op,
    input  logic [`XLEN-1:0]         rs1_op,
    input  logic [`XLEN-1:0]         rs2_op,
    input  logic [`IMM_W-1:0]        imm,
    input  logic [`XLEN-1:0]         pc,
    input  logic                     valid,
    output ex_pipe_pkg::redirect_t   redirect
);

    import rv_isa_pkg::*;

    logic               eq;
    logic               lt;
    logic               ltu;
    logic               cond;
    logic [`XLEN-1:0]   imm_sx;
    logic [`XLEN-1:0]   jalr_sum;

    assign imm_sx   = sext_imm(imm);
    assign jalr_sum = rs1_op + imm_sx;

    assign eq  = (rs1_op == rs2_op);
    assign lt  = ($signed(rs1_op) < $signed(rs2_op));
    assign ltu = (rs1_op < rs2_op);

    always_comb begin
        case (op)
            op_beq:          cond = eq;
            op_bne:          cond = !eq;
            op_blt:          cond = lt;
            op_bge:          cond = !lt;
            op_bltu:         cond = ltu;
            op_bgeu:         cond = !ltu;
            op_jal, op_jalr: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    // bubbles never redirect
    assign redirect.taken = valid && cond;

    // jalr target is register based with bit 0 cleared
    assign redirect.target = (op == op_jalr) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + imm_sx;

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  ex_pipe_pkg::id_ex_t      id_ex,
    input  ex_pipe_pkg::fwd_t        mem_fwd,
    input  ex_pipe_pkg::fwd_t        wb_fwd,
    input  logic                     mem_stall,
    output ex_pipe_pkg::ex_mem_t     ex_mem,
    output ex_pipe_pkg::redirect_t   redirect,
    output logic                     stall_id
);

    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    id_ex_t             ex_d;
    id_ex_t             ex_q;
    logic [`XLEN-1:0]   rs1_op;
    logic [`XLEN-1:0]   rs2_op;
    logic [`XLEN-1:0]   alu_result;
    logic               load_use;
    logic               mem_en;
    logic               is_load;
    logic               is_unsigned;
    logic               writes_rd;
    access_size_e       size;

    operand_bypass u_bypass (
        .id_ex    (id_ex),
        .ex_fwd   (ex_mem),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd),
        .rs1_op   (rs1_op),
        .rs2_op   (rs2_op),
        .load_use (load_use)
    );

    assign stall_id = load_use | mem_stall;

    // forwarded operands replace the decode values;
    // load-use and wrong-path instructions become bubbles
    always_comb begin
        ex_d         = id_ex;
        ex_d.rs1_val = rs1_op;
        ex_d.rs2_val = rs2_op;
        ex_d.valid   = id_ex.valid && !load_use && !redirect.taken;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_q.valid <= 1'b0;
        end else if (!mem_stall) begin
            ex_q <= ex_d;
        end
    end

    int_alu u_alu (
        .op     (ex_q.op),
        .rs1_op (ex_q.rs1_val),
        .rs2_op (ex_q.rs2_val),
        .imm    (ex_q.imm),
        .pc     (ex_q.pc),
        .result (alu_result)
    );

    branch_unit u_branch (
        .op       (ex_q.op),
        .rs1_op   (ex_q.rs1_val),
        .rs2_op   (ex_q.rs2_val),
        .imm      (ex_q.imm),
        .pc       (ex_q.pc),
        .valid    (ex_q.valid),
        .redirect (redirect)
    );

    // memory-op decode of the registered opcode
    always_comb begin
        mem_en      = 1'b0;
        is_load     = 1'b0;
        is_unsigned = 1'b0;
        writes_rd   = 1'b1;
        size        = size_double;
        case (ex_q.op)
            op_lb, op_lbu: begin
                mem_en  = 1'b1;
                is_load = 1'b1;
                size    = size_byte;
            end
            op_lh, op_lhu: begin
                mem_en  = 1'b1;
                is_load = 1'b1;
                size    = size_half;
            end
            op_lw, op_lwu: begin
                mem_en  = 1'b1;
                is_load = 1'b1;
                size    = size_word;
            end
            op_ld: begin
                mem_en  = 1'b1;
                is_load = 1'b1;
            end
            op_sb, op_sh, op_sw, op_sd: begin
                mem_en    = 1'b1;
                writes_rd = 1'b0;
                size      = (ex_q.op == op_sb) ? size_byte :
                            (ex_q.op == op_sh) ? size_half :
                            (ex_q.op == op_sw) ? size_word : size_double;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_nop: begin
                writes_rd = 1'b0;
            end
            default: begin
            end
        endcase
        is_unsigned = (ex_q.op == op_lbu) || (ex_q.op == op_lhu) || (ex_q.op == op_lwu);
    end

    always_comb begin
        ex_mem.valid       = ex_q.valid;
        ex_mem.wb_en       = ex_q.valid && writes_rd;
        ex_mem.rd          = ex_q.rd;
        ex_mem.result      = alu_result;
        ex_mem.store_data  = ex_q.rs2_val;
        ex_mem.mem_en      = ex_q.valid && mem_en;
        ex_mem.load        = ex_q.valid && is_load;
        ex_mem.size        = size;
        ex_mem.is_unsigned = is_unsigned;
    end

endmodule

`default_nettype wire

// ==== ex_stage_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions (
    input logic                     clk,
    input logic                     reset,
    input logic                     mem_stall,
    input logic                     load_use,
    input ex_pipe_pkg::ex_mem_t     ex_mem,
    input ex_pipe_pkg::redirect_t   redirect
);

    // failure count, looked at when the run ends
    int failures = 0;

    // a reset edge clears everything leaving execute
    reset_clears_outputs: assert property (@(posedge clk)
        reset |=> !ex_mem.valid && !ex_mem.wb_en && !ex_mem.mem_en && !redirect.taken)
    else begin
        failures++;
        $error("execute outputs not cleared after a reset cycle");
    end

    // memory back-pressure freezes the pipeline register
    stall_holds_ex_mem: assert property (@(posedge clk) disable iff (reset)
        mem_stall |=> $stable(ex_mem))
    else begin
        failures++;
        $error("ex_mem changed while mem_stall was high");
    end

    load_use_bubble: assert property (@(posedge clk) disable iff (reset)
        load_use && !mem_stall |=> !ex_mem.valid && !ex_mem.wb_en && !ex_mem.mem_en)
    else begin
        failures++;
        $error("no bubble after a load-use stall");
    end

endmodule

`default_nettype wire

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    logic        clk;
    logic        reset;
    logic        mem_stall;
    logic        stall_id;
    id_ex_t      id_ex;
    fwd_t        mem_fwd;
    fwd_t        wb_fwd;
    ex_mem_t     ex_mem;
    redirect_t   redirect;
    string       test_name;

    ex_stage dut (.*);

    bind ex_stage ex_stage_assertions u_assertions (
        .clk(clk), .reset(reset), .mem_stall(mem_stall), .load_use(load_use),
        .ex_mem(ex_mem), .redirect(redirect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("Error in %s, %s: expected %h, actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // sign extension from any bit position
    function automatic logic [63:0] sx(input logic [63:0] v, input int bits);
        logic [63:0] upper;
        upper = ~64'h0 << bits;
        return v[bits-1] ? (v | upper) : (v & ~upper);
    endfunction

    // valid instruction with a random pc
    function automatic id_ex_t make_instr(input opcode_e op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [63:0] a, input logic [63:0] b,
                                          input logic [19:0] imm);
        return '{1'b1, op, rd, rs1, rs2, a, b, imm, rand64()};
    endfunction

    function automatic logic [63:0] ref_alu(input opcode_e op, input logic [63:0] a,
                                            input logic [63:0] b, input logic [63:0] i,
                                            input logic [63:0] pc);
        if (op inside {op_addi, op_andi, op_ori, op_xori, op_slli, op_srli, op_srai,
                       op_slti, op_sltiu, op_addiw, op_slliw, op_srliw, op_sraiw}) begin
            b = i;
        end
        case (op)
            op_add, op_addi:   return a + b;
            op_sub:            return a - b;
            op_and, op_andi:   return a & b;
            op_or, op_ori:     return a | b;
            op_xor, op_xori:   return a ^ b;
            op_sll, op_slli:   return a << b[5:0];
            op_srl, op_srli:   return a >> b[5:0];
            op_sra, op_srai:   return $signed(a) >>> b[5:0];
            op_slt, op_slti:   return {63'd0, $signed(a) < $signed(b)};
            op_sltu, op_sltiu: return {63'd0, a < b};
            op_addw, op_addiw: return sx(a + b, 32);
            op_subw:           return sx(a - b, 32);
            op_sllw, op_slliw: return sx(a << b[4:0], 32);
            op_srlw, op_srliw: return sx({32'd0, a[31:0]} >> b[4:0], 32);
            // sign-extend first so a 64-bit arithmetic shift gives the word result
            op_sraw, op_sraiw: return $signed(sx(a, 32)) >>> b[4:0];
            op_lui:            return i << 12;
            op_auipc:          return pc + (i << 12);
            default:           return 64'd0;
        endcase
    endfunction

    function automatic logic ref_taken(input opcode_e op, input logic [63:0] a,
                                       input logic [63:0] b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return $signed(a) < $signed(b);
            op_bge:  return $signed(a) >= $signed(b);
            op_bltu: return a < b;
            op_bgeu: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic access_size_e access_size(input opcode_e op);
        case (op)
            op_lb, op_lbu, op_sb: return size_byte;
            op_lh, op_lhu, op_sh: return size_half;
            op_lw, op_lwu, op_sw: return size_word;
            default:              return size_double;
        endcase
    endfunction

    // drive one instruction, return on the falling edge after it was accepted
    task automatic issue(input id_ex_t instr, output int stalls);
        stalls = 0;
        id_ex  = instr;
        #1;
        while (stall_id) begin
            @(negedge clk);
            #1;
            stalls++;
            if (stalls > 16) begin
                stop_run($sformatf("%s: timed out waiting for stall_id to drop", test_name));
            end
        end
        @(posedge clk);
        @(negedge clk);
        id_ex.valid = 1'b0;
    endtask

    task automatic sweep_alu_ops();
        id_ex_t  t;
        int      s;
        test_name = "alu";
        for (int k = int'(op_add); k <= int'(op_auipc); k++) begin
            repeat (4) begin
                t = make_instr(opcode_e'(k), 5'd1, 5'd2, 5'd3, rand64(), rand64(),
                               20'($urandom));
                issue(t, s);
                check(t.op.name(), ref_alu(t.op, t.rs1_val, t.rs2_val,
                                           sx(64'(t.imm), 20), t.pc), ex_mem.result);
                check("rd", t.rd, ex_mem.rd);
                check("wb_en", 1, ex_mem.wb_en);
                check("mem_en", 0, ex_mem.mem_en);
            end
        end
    endtask

    task automatic exercise_memory_ops();
        id_ex_t  t;
        int      s;
        logic    load;
        test_name = "memory";
        for (int k = int'(op_lb); k <= int'(op_sd); k++) begin
            t = make_instr(opcode_e'(k), 5'd4, 5'd5, 5'd6, rand64(), rand64(), 20'($urandom));
            issue(t, s);
            load = t.op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
            check("address", t.rs1_val + sx(64'(t.imm), 20), ex_mem.result);
            check("mem_en", 1, ex_mem.mem_en);
            check("load", load, ex_mem.load);
            check("wb_en", load, ex_mem.wb_en);
            check("size", access_size(t.op), ex_mem.size);
            check("unsigned", t.op inside {op_lbu, op_lhu, op_lwu}, ex_mem.is_unsigned);
            check("store_data", t.rs2_val, ex_mem.store_data);
        end
    endtask

    task automatic resolve_branches();
        id_ex_t       t;
        int           s;
        logic         taken;
        logic         jump;
        logic [63:0]  target;
        logic [63:0]  a [3];
        logic [63:0]  b [3];
        test_name = "branch";
        // equal, signed-less and unsigned-less operand pairs
        a[0] = rand64();
        b[0] = a[0];
        a[1] = '1;
        b[1] = 64'd1;
        a[2] = 64'd1;
        b[2] = '1;
        for (int k = int'(op_beq); k <= int'(op_jalr); k++) begin
            for (int p = 0; p < 3; p++) begin
                t = make_instr(opcode_e'(k), 5'd8, 5'd2, 5'd3, a[p], b[p], 20'($urandom));
                issue(t, s);
                jump   = t.op inside {op_jal, op_jalr};
                taken  = ref_taken(t.op, a[p], b[p]);
                target = t.pc + sx(64'(t.imm), 20);
                if (t.op == op_jalr) begin
                    target = (a[p] + sx(64'(t.imm), 20)) & ~64'h1;
                end
                check("valid", 1, ex_mem.valid);
                check("taken", taken, redirect.taken);
                check("wb_en", jump, ex_mem.wb_en);
                if (taken) begin
                    check("target", target, redirect.target);
                end
                if (jump) begin
                    check("link", t.pc + 64'd4, ex_mem.result);
                end
                // wrong-path instruction right behind a taken redirect
                t = make_instr(op_addi, 5'd7, 5'd0, 5'd0, rand64(), rand64(), 20'h0);
                issue(t, s);
                check("squash", !taken, ex_mem.valid);
            end
        end
    endtask

    task automatic chain_forwarding();
        id_ex_t       t;
        int           s;
        logic [63:0]  m;
        logic [63:0]  w;
        logic [63:0]  prev;
        test_name = "forwarding";
        m = rand64();
        w = rand64();
        mem_fwd = '{1'b1, 5'd10, m};
        wb_fwd  = '{1'b1, 5'd13, w};
        t = make_instr(op_addi, 5'd10, 5'd0, 5'd0, rand64(), rand64(), 20'($urandom));
        issue(t, s);
        prev = t.rs1_val + sx(64'(t.imm), 20);
        check("producer", prev, ex_mem.result);
        // x10 from execute beats memory, x13 from writeback
        t = make_instr(op_add, 5'd11, 5'd10, 5'd13, rand64(), rand64(), 20'h0);
        issue(t, s);
        check("ex over mem", prev + w, ex_mem.result);
        m = rand64();
        w = rand64();
        mem_fwd = '{1'b1, 5'd12, m};
        wb_fwd  = '{1'b1, 5'd12, w};
        t = make_instr(op_add, 5'd14, 5'd12, 5'd13, rand64(), rand64(), 20'h0);
        issue(t, s);
        check("mem over wb", m + t.rs2_val, ex_mem.result);
        mem_fwd = '{1'b1, 5'd0, m};
        t = make_instr(op_add, 5'd15, 5'd0, 5'd12, rand64(), rand64(), 20'h0);
        issue(t, s);
        check("x0 and wb", t.rs1_val + w, ex_mem.result);
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    task automatic stall_scenarios();
        id_ex_t       t;
        id_ex_t       hold;
        int           s;
        logic [63:0]  data;
        logic [63:0]  kept;
        test_name = "load-use";
        t = make_instr(op_ld, 5'd16, 5'd0, 5'd0, rand64(), rand64(), 20'($urandom));
        issue(t, s);
        check("load", 1, ex_mem.load);
        // load data shows up from memory once the bubble has passed
        data = rand64();
        mem_fwd = '{1'b1, 5'd16, data};
        t = make_instr(op_add, 5'd17, 5'd16, 5'd0, rand64(), rand64(), 20'h0);
        issue(t, s);
        check("stall cycles", 1, s);
        check("sum", data + t.rs2_val, ex_mem.result);
        mem_fwd = '0;
        t = make_instr(op_lw, 5'd0, 5'd0, 5'd0, rand64(), rand64(), 20'($urandom));
        issue(t, s);
        t = make_instr(op_add, 5'd18, 5'd0, 5'd0, rand64(), rand64(), 20'h0);
        issue(t, s);
        check("x0 stall cycles", 0, s);
        check("x0 sum", t.rs1_val + t.rs2_val, ex_mem.result);
        test_name = "back-pressure";
        kept = t.rs1_val + t.rs2_val;
        hold = make_instr(op_xori, 5'd19, 5'd0, 5'd0, rand64(), rand64(), 20'($urandom));
        mem_stall = 1'b1;
        id_ex     = hold;
        #1;
        check("stall_id", 1, stall_id);
        repeat (3) begin
            @(negedge clk);
            check("held result", kept, ex_mem.result);
            check("held valid", 1, ex_mem.valid);
            check("stall_id", 1, stall_id);
        end
        mem_stall = 1'b0;
        issue(hold, s);
        check("after release", hold.rs1_val ^ sx(64'(hold.imm), 20), ex_mem.result);
        check("rd", hold.rd, ex_mem.rd);
    endtask

    initial begin
        void'($urandom(32'h65a2));
        test_name = "reset";
        reset     = 1'b1;
        mem_stall = 1'b0;
        id_ex     = '0;
        mem_fwd   = '0;
        wb_fwd    = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("valid", 0, ex_mem.valid);
        check("wb_en", 0, ex_mem.wb_en);
        check("mem_en", 0, ex_mem.mem_en);
        check("taken", 0, redirect.taken);
        sweep_alu_ops();
        exercise_memory_ops();
        resolve_branches();
        chain_forwarding();
        stall_scenarios();
        if (dut.u_assertions.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
rv_isa_pkg.sv
ex_pipe_pkg.sv
operand_bypass.sv
int_alu.sv
branch_unit.sv
ex_stage.sv
ex_stage_assertions.sv
tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - ex_pipe_pkg.sv
      - operand_bypass.sv
      - int_alu.sv
      - branch_unit.sv
      - ex_stage.sv
      - target: test
        files:
          - ex_stage_assertions.sv
          - tb_ex_stage.sv
